// ==== verilog/pet_spi_pkg.sv ====
// Shared definitions for the SPI host-access path
//   Bus address and data widths
//   Command byte bit positions
//   SPI synchronizer depth and bit counter width
//   APB RAM wait-state timing
//   Bridge FSM state type

`default_nettype none

package pet_spi_pkg;

    // Bus geometry
    localparam int ADDR_W = 17;           // Byte address, A16..A0
    localparam int DATA_W = 8;

    // Command byte fields
    localparam int CMD_RD_BIT   = 7;      // 1 = read, 0 = write
    localparam int CMD_ADDR_BIT = 6;      // Two address bytes follow
    localparam int CMD_A16_BIT  = 0;      // A16 when an address follows

    // SPI pin synchronizer
    localparam int SYNC_STAGES = 2;
    localparam int BIT_CNT_W   = $clog2(DATA_W);

    // RAM access timing
    localparam int RAM_WAIT_STATES = 1;   // Access cycles with pready low
    localparam int RAM_WAIT_W      = $clog2(RAM_WAIT_STATES + 2);

    typedef enum logic [2:0] {
        READ_CMD,
        READ_DATA_ARG,
        READ_ADDR_HI_ARG,
        READ_ADDR_LO_ARG,
        XFER_SETUP,
        XFER_ACCESS,
        DONE
    } bridge_state_e;

endpackage

`default_nettype wire

// ==== verilog/spi_byte.sv ====
// SPI mode 0 byte shifter, MSB first
//   Two-flop synchronizers on SCLK, CS and MOSI
//   SCLK edge detection in the system clock domain
//   Receive shift register with byte-valid strobe
//   Transmit shift register feeding MISO

`default_nettype none

module spi_byte
    import pet_spi_pkg::*;
(
    input  logic              clk_sys_i,
    input  logic              reset,
    input  logic              spi_sclk_i,
    input  logic              spi_cs_ni,
    input  logic              spi_mosi_i,
    output logic              spi_miso_o,
    input  logic [DATA_W-1:0] tx_byte_i,
    output logic [DATA_W-1:0] rx_byte_o,
    output logic              rx_valid_o,
    output logic              cs_active_o
);

    logic [SYNC_STAGES-1:0] sclk_sync;
    logic [SYNC_STAGES-1:0] cs_sync;
    logic [SYNC_STAGES-1:0] mosi_sync;
    logic                   sclk_q;      // Previous synchronized SCLK
    logic [BIT_CNT_W-1:0]   bit_cnt;
    logic [DATA_W-1:0]      rx_shift;
    logic [DATA_W-1:0]      tx_shift;
    logic                   sclk_rise;
    logic                   sclk_fall;

    always_ff @(posedge clk_sys_i or posedge reset) begin
        if (reset) begin
            sclk_sync <= '0;
            cs_sync   <= '1;             // Idle with chip select inactive
            mosi_sync <= '0;
            sclk_q    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], spi_sclk_i};
            cs_sync   <= {cs_sync[SYNC_STAGES-2:0], spi_cs_ni};
            mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi_i};
            sclk_q    <= sclk_sync[SYNC_STAGES-1];
        end
    end

    assign sclk_rise   = sclk_sync[SYNC_STAGES-1] & ~sclk_q;
    assign sclk_fall   = ~sclk_sync[SYNC_STAGES-1] & sclk_q;
    assign cs_active_o = ~cs_sync[SYNC_STAGES-1];

    // Bit counter and byte strobe
    always_ff @(posedge clk_sys_i or posedge reset) begin
        if (reset) begin
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (!cs_active_o) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                bit_cnt    <= bit_cnt + 1'b1;
                rx_valid_o <= (bit_cnt == BIT_CNT_W'(DATA_W - 1));
            end
        end
    end

    // Data shift registers
    always_ff @(posedge clk_sys_i) begin
        if (cs_active_o && sclk_rise) begin
            rx_shift <= {rx_shift[DATA_W-2:0], mosi_sync[SYNC_STAGES-1]};
        end else if (cs_active_o && sclk_fall) begin
            // MSB already went out directly, so load the rest on the first fall
            if (bit_cnt == BIT_CNT_W'(1)) begin
                tx_shift <= {tx_byte_i[DATA_W-2:0], 1'b0};
            end else begin
                tx_shift <= {tx_shift[DATA_W-2:0], 1'b0};
            end
        end
    end

    assign rx_byte_o = rx_shift;

    // Between bytes MISO shows the MSB of the pending byte
    assign spi_miso_o = (bit_cnt == '0) ? tx_byte_i[DATA_W-1] : tx_shift[DATA_W-1];

endmodule

`default_nettype wire

// ==== verilog/spi_bridge.sv ====
// SPI command-frame decoder and APB master
//   Command byte decode and argument collection FSM
//   Retained address register with auto-increment
//   One APB transfer per frame
//   Read data return to the byte shifter

`default_nettype none

module spi_bridge
    import pet_spi_pkg::*;
(
    input  logic              clk_sys_i,
    input  logic              reset,
    input  logic [DATA_W-1:0] rx_byte_i,
    input  logic              rx_valid_i,
    input  logic              cs_active_i,
    output logic [DATA_W-1:0] tx_byte_o,
    output logic [ADDR_W-1:0] paddr_o,
    output logic [DATA_W-1:0] pwdata_o,
    output logic              pwrite_o,
    output logic              psel_o,
    output logic              penable_o,
    input  logic [DATA_W-1:0] prdata_i,
    input  logic              pready_i,
    output logic              xfer_done_o
);

    bridge_state_e state;
    logic          cmd_addr;                      // Frame carries an address
    logic [ADDR_W-1:DATA_W] addr_stage;           // A16 and high byte until commit
    logic          in_xfer;

    assign in_xfer = (state == XFER_SETUP) || (state == XFER_ACCESS);

    // APB control follows the FSM directly
    assign psel_o    = in_xfer;
    assign penable_o = (state == XFER_ACCESS);

    always_ff @(posedge clk_sys_i or posedge reset) begin
        if (reset) begin
            state       <= READ_CMD;
            cmd_addr    <= 1'b0;
            pwrite_o    <= 1'b0;
            paddr_o     <= '0;
            tx_byte_o   <= '0;
            xfer_done_o <= 1'b0;
        end else if (!cs_active_i && !in_xfer) begin
            // Frame ended or aborted, an APB access in flight finishes first
            state       <= READ_CMD;
            xfer_done_o <= 1'b0;
        end else begin
            case (state)
                READ_CMD: begin
                    xfer_done_o <= 1'b0;
                    if (rx_valid_i) begin
                        pwrite_o <= ~rx_byte_i[CMD_RD_BIT];
                        cmd_addr <= rx_byte_i[CMD_ADDR_BIT];
                        if (!rx_byte_i[CMD_RD_BIT]) begin
                            state <= READ_DATA_ARG;        // Write, data comes first
                        end else if (rx_byte_i[CMD_ADDR_BIT]) begin
                            state <= READ_ADDR_HI_ARG;
                        end else begin
                            state <= XFER_SETUP;           // Read at current address
                        end
                    end
                end

                READ_DATA_ARG: begin
                    if (rx_valid_i) begin
                        state <= cmd_addr ? READ_ADDR_HI_ARG : XFER_SETUP;
                    end
                end

                READ_ADDR_HI_ARG: begin
                    if (rx_valid_i) begin
                        state <= READ_ADDR_LO_ARG;
                    end
                end

                READ_ADDR_LO_ARG: begin
                    if (rx_valid_i) begin
                        paddr_o <= {addr_stage, rx_byte_i};   // Commit full address
                        state   <= XFER_SETUP;
                    end
                end

                XFER_SETUP: begin
                    state <= XFER_ACCESS;
                end

                XFER_ACCESS: begin
                    // SPI bytes arriving while stalled here are dropped
                    if (pready_i) begin
                        paddr_o     <= paddr_o + 1'b1;
                        xfer_done_o <= 1'b1;
                        if (!pwrite_o) begin
                            tx_byte_o <= prdata_i;
                        end
                        state <= DONE;
                    end
                end

                DONE: begin
                    state <= DONE;                         // Hold until CS rises
                end

                default: begin
                    state <= READ_CMD;
                end
            endcase
        end
    end

    // Frame arguments, only the decoded state decides when they are used
    always_ff @(posedge clk_sys_i) begin
        if (rx_valid_i && cs_active_i) begin
            case (state)
                READ_CMD: begin
                    addr_stage[ADDR_W-1] <= rx_byte_i[CMD_A16_BIT];
                end
                READ_DATA_ARG: begin
                    pwdata_o <= rx_byte_i;
                end
                READ_ADDR_HI_ARG: begin
                    addr_stage[ADDR_W-2:DATA_W] <= rx_byte_i;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/apb_ram.sv ====
// APB slave byte memory
//   Byte array covering the full bus address space
//   Fixed wait states before pready
//   Write on the completing access cycle
//   Registered read, valid from the first access cycle

`default_nettype none

module apb_ram
    import pet_spi_pkg::*;
(
    input  logic              clk_sys_i,
    input  logic              reset,
    input  logic [ADDR_W-1:0] paddr_i,
    input  logic [DATA_W-1:0] pwdata_i,
    input  logic              pwrite_i,
    input  logic              psel_i,
    input  logic              penable_i,
    output logic [DATA_W-1:0] prdata_o,
    output logic              pready_o
);

    logic [DATA_W-1:0]     mem [2**ADDR_W];
    logic [RAM_WAIT_W-1:0] wait_cnt;
    logic                  access;

    assign access   = psel_i & penable_i;
    assign pready_o = access && (wait_cnt == RAM_WAIT_W'(RAM_WAIT_STATES));

    // Wait-state counter
    always_ff @(posedge clk_sys_i or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (!access || pready_o) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (access && pready_o && pwrite_i) begin
            mem[paddr_i] <= pwdata_i;
        end
    end

    // Address is stable from setup, so a read started then is ready at completion
    always_ff @(posedge clk_sys_i) begin
        if (psel_i && !pwrite_i) begin
            prdata_o <= mem[paddr_i];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pet_spi_top.sv ====
// Top level of the SPI host-access path
//   SPI byte shifter
//   Command decoder and APB master
//   APB RAM slave

`default_nettype none

module pet_spi_top
    import pet_spi_pkg::*;
(
    input  logic clk_sys_i,
    input  logic reset,
    input  logic spi_sclk_i,
    input  logic spi_cs_ni,
    input  logic spi_mosi_i,
    output logic spi_miso_o,
    output logic xfer_done_o
);

    logic [DATA_W-1:0] rx_byte;
    logic              rx_valid;
    logic              cs_active;
    logic [DATA_W-1:0] tx_byte;

    // APB between bridge and RAM
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pwrite;
    logic              psel;
    logic              penable;
    logic              pready;

    spi_byte u_spi_byte (
        .clk_sys_i   (clk_sys_i),
        .reset       (reset),
        .spi_sclk_i  (spi_sclk_i),
        .spi_cs_ni   (spi_cs_ni),
        .spi_mosi_i  (spi_mosi_i),
        .spi_miso_o  (spi_miso_o),
        .tx_byte_i   (tx_byte),
        .rx_byte_o   (rx_byte),
        .rx_valid_o  (rx_valid),
        .cs_active_o (cs_active)
    );

    spi_bridge u_spi_bridge (
        .clk_sys_i   (clk_sys_i),
        .reset       (reset),
        .rx_byte_i   (rx_byte),
        .rx_valid_i  (rx_valid),
        .cs_active_i (cs_active),
        .tx_byte_o   (tx_byte),
        .paddr_o     (paddr),
        .pwdata_o    (pwdata),
        .pwrite_o    (pwrite),
        .psel_o      (psel),
        .penable_o   (penable),
        .prdata_i    (prdata),
        .pready_i    (pready),
        .xfer_done_o (xfer_done_o)
    );

    apb_ram u_apb_ram (
        .clk_sys_i (clk_sys_i),
        .reset     (reset),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .pwrite_i  (pwrite),
        .psel_i    (psel),
        .penable_i (penable),
        .prdata_o  (prdata),
        .pready_o  (pready)
    );

endmodule

`default_nettype wire

// ==== testbench/pet_spi_checker.sv ====
// Bound protocol checks for the SPI bridge
//   APB access phase held until pready, closed after it
//   APB signal stability in the access phase
//   Bridge outputs right after reset
//   At most one APB transfer per chip-select frame

`default_nettype none

module pet_spi_checker
    import pet_spi_pkg::*;
(
    input logic              clk_sys_i,
    input logic              reset,
    input logic              cs_active_i,
    input bridge_state_e     state_i,
    input logic              psel_i,
    input logic              penable_i,
    input logic              pwrite_i,
    input logic [ADDR_W-1:0] paddr_i,
    input logic [DATA_W-1:0] pwdata_i,
    input logic              pready_i,
    input logic              xfer_done_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Failure counts, read by the testbench
    int          fail_access = 0;
    int          fail_stable = 0;
    int          fail_reset  = 0;
    int          fail_setup  = 0;
    logic [31:0] fail_count;
    logic        cs_q;
    logic        setup_seen;       // XFER_SETUP already entered in this frame

    assign fail_count = fail_access + fail_stable + fail_reset + fail_setup;

    always_ff @(posedge clk_sys_i or posedge reset) begin
        if (reset) begin
            cs_q       <= 1'b0;
            setup_seen <= 1'b0;
        end else begin
            cs_q <= cs_active_i;
            if (cs_active_i && !cs_q) begin
                setup_seen <= 1'b0;                     // Chip select just fell
            end else if (state_i == XFER_SETUP) begin
                setup_seen <= 1'b1;
            end
        end
    end

    // Stalled access keeps psel and penable, a completed one drops both
    access_until_ready: assert property (@(posedge clk_sys_i) disable iff (reset)
        penable_i |=> ($past(pready_i) ? (!psel_i && !penable_i) : (psel_i && penable_i)))
        else begin
            $error("APB access phase not held until pready or not closed after it");
            fail_access++;
        end

    access_stable: assert property (@(posedge clk_sys_i) disable iff (reset)
        penable_i |-> $stable(paddr_i) && $stable(pwdata_i) && $stable(pwrite_i))
        else begin
            $error("APB address, data or direction changed in access phase");
            fail_stable++;
        end

    idle_after_reset: assert property (@(posedge clk_sys_i)
        $fell(reset) |-> !psel_i && !xfer_done_i)
        else begin
            $error("psel or xfer_done high in the first cycle after reset");
            fail_reset++;
        end

    one_setup_per_frame: assert property (@(posedge clk_sys_i) disable iff (reset)
        (state_i == XFER_SETUP) |-> !setup_seen)
        else begin
            $error("Second APB transfer within one chip-select frame");
            fail_setup++;
        end

endmodule

bind spi_bridge pet_spi_checker u_checker (
    .clk_sys_i   (clk_sys_i),
    .reset       (reset),
    .cs_active_i (cs_active_i),
    .state_i     (state),
    .psel_i      (psel_o),
    .penable_i   (penable_o),
    .pwrite_i    (pwrite_o),
    .paddr_i     (paddr_o),
    .pwdata_i    (pwdata_o),
    .pready_i    (pready_i),
    .xfer_done_i (xfer_done_o)
);

`default_nettype wire

// ==== testbench/tb_pet_spi.sv ====
// Testbench for the SPI host-access path
//   Clock, reset and SPI mode 0 master tasks
//   Reference memory and model address register
//   Directed tests with random addresses and data

`default_nettype none

module tb_pet_spi
    import pet_spi_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_HALF    = 20;
    localparam int          DRIVE_DLY   = 5;
    localparam int          SCLK_HALF   = 4;      // System clocks per SCLK phase
    localparam int          CS_GAP      = 16;
    localparam int          DONE_WAIT   = 200;
    localparam int          CYCLE_LIMIT = 30000;
    localparam logic [31:0] SEED        = 32'h1cbcea42;

    logic clk_sys;
    logic reset;
    logic spi_sclk;
    logic spi_cs_n;
    logic spi_mosi;
    logic spi_miso;
    logic xfer_done;

    logic [DATA_W-1:0] ref_mem [2**ADDR_W];
    logic [ADDR_W-1:0] model_addr;                // Follows the DUT address register
    int                error_count = 0;
    int                check_count = 0;
    int                tests_run   = 0;
    int                tests_failed = 0;
    int                test_start_errors;
    int                cycles;

    pet_spi_top UUT (
        .clk_sys_i   (clk_sys),
        .reset       (reset),
        .spi_sclk_i  (spi_sclk),
        .spi_cs_ni   (spi_cs_n),
        .spi_mosi_i  (spi_mosi),
        .spi_miso_o  (spi_miso),
        .xfer_done_o (xfer_done)
    );

    initial begin
        clk_sys = 1'b0;
        forever begin
            #CLK_HALF clk_sys = ~clk_sys;
        end
    end

    function automatic int error_total();
        return error_count + int'(UUT.u_spi_bridge.u_checker.fail_count);
    endfunction

    // One byte in mode 0, MISO captured at each rising SCLK
    task automatic shift_byte(input logic [DATA_W-1:0] tx, output logic [DATA_W-1:0] rx);
        int i;
        rx = '0;
        for (i = DATA_W - 1; i >= 0; i--) begin
            spi_mosi = tx[i];
            repeat (SCLK_HALF) @(posedge clk_sys);
            #DRIVE_DLY;
            spi_sclk = 1'b1;
            rx[i]    = spi_miso;
            repeat (SCLK_HALF) @(posedge clk_sys);
            #DRIVE_DLY;
            spi_sclk = 1'b0;
        end
    endtask

    task automatic select_slave();
        spi_cs_n = 1'b0;
        repeat (SCLK_HALF) @(posedge clk_sys);
        #DRIVE_DLY;
    endtask

    task automatic release_slave();
        spi_cs_n = 1'b1;
        repeat (CS_GAP) @(posedge clk_sys);
        #DRIVE_DLY;
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        while (!xfer_done && n < DONE_WAIT) begin
            @(posedge clk_sys);
            #DRIVE_DLY;
            n++;
        end
        if (!xfer_done) begin
            $display("Transfer did not complete within %0d cycles at %0t", DONE_WAIT, $time);
            error_count++;
        end
    endtask

    task automatic compare_byte(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] got);
        check_count++;
        assert (got === ref_mem[addr]) else begin
            $display("Error at %0t: address %h read %h, expected %h",
                     $time, addr, got, ref_mem[addr]);
            error_count++;
        end
    endtask

    task automatic write_frame(input logic use_addr, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] cmd;
        logic [DATA_W-1:0] rx;
        cmd               = '0;
        cmd[CMD_ADDR_BIT] = use_addr;
        cmd[CMD_A16_BIT]  = use_addr & addr[ADDR_W-1];
        select_slave();
        shift_byte(cmd, rx);
        shift_byte(data, rx);
        if (use_addr) begin
            shift_byte(addr[ADDR_W-2:DATA_W], rx);
            shift_byte(addr[DATA_W-1:0], rx);
            model_addr = addr;
        end
        wait_for_done();
        release_slave();
        ref_mem[model_addr] = data;
        model_addr          = model_addr + 1'b1;
    endtask

    task automatic read_frame(input logic use_addr, input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] cmd;
        logic [DATA_W-1:0] rx;
        cmd               = '0;
        cmd[CMD_RD_BIT]   = 1'b1;
        cmd[CMD_ADDR_BIT] = use_addr;
        cmd[CMD_A16_BIT]  = use_addr & addr[ADDR_W-1];
        select_slave();
        shift_byte(cmd, rx);
        if (use_addr) begin
            shift_byte(addr[ADDR_W-2:DATA_W], rx);
            shift_byte(addr[DATA_W-1:0], rx);
            model_addr = addr;
        end
        wait_for_done();
        cmd[CMD_ADDR_BIT] = 1'b0;                 // Dummy is a plain read command, ignored in DONE
        shift_byte(cmd, rx);                      // Dummy byte carries the read data
        release_slave();
        compare_byte(model_addr, rx);
        model_addr = model_addr + 1'b1;
    endtask

    // Write command only, then chip select rises
    task automatic abort_frame();
        logic [DATA_W-1:0] rx;
        select_slave();
        shift_byte('0, rx);
        release_slave();
    endtask

    task automatic start_test();
        test_start_errors = error_total();
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (error_total() == test_start_errors) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed", tests_run, name);
        end
    endtask

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        int                k;
        reset      = 1'b1;
        spi_sclk   = 1'b0;
        spi_cs_n   = 1'b1;
        spi_mosi   = 1'b0;
        model_addr = '0;
        void'($urandom(SEED));
        repeat (3) @(posedge clk_sys);
        #DRIVE_DLY;
        reset = 1'b0;
        release_slave();

        start_test();
        repeat (5) begin
            addr = ADDR_W'($urandom);
            write_frame(1'b1, addr, DATA_W'($urandom));
            read_frame(1'b1, addr);
        end
        report_test("write then read back");

        start_test();
        addr = ADDR_W'($urandom);
        write_frame(1'b1, addr, DATA_W'($urandom));
        for (k = 1; k < 4; k++) begin
            write_frame(1'b0, '0, DATA_W'($urandom));   // Lands at previous address + 1
        end
        for (k = 0; k < 4; k++) begin
            read_frame(1'b1, ADDR_W'(addr + k));
        end
        report_test("write auto-increment");

        start_test();
        addr = ADDR_W'($urandom);
        for (k = 0; k < 4; k++) begin
            write_frame(1'b1, ADDR_W'(addr + k), DATA_W'($urandom));
        end
        read_frame(1'b1, addr);
        for (k = 1; k < 4; k++) begin
            read_frame(1'b0, '0);
        end
        report_test("read auto-increment");

        start_test();
        addr = {1'b0, 16'($urandom)};
        data = DATA_W'($urandom);
        write_frame(1'b1, addr, data);
        write_frame(1'b1, {1'b1, addr[ADDR_W-2:0]}, data ^ (DATA_W'($urandom) | 8'h01));
        read_frame(1'b1, addr);
        read_frame(1'b1, {1'b1, addr[ADDR_W-2:0]});
        report_test("address bit 16");

        start_test();
        addr = ADDR_W'($urandom);
        write_frame(1'b1, ADDR_W'(addr + 1), DATA_W'($urandom));
        write_frame(1'b1, addr, DATA_W'($urandom));
        abort_frame();
        read_frame(1'b0, '0);                           // Next address still holds its byte
        addr = ADDR_W'($urandom);
        write_frame(1'b1, addr, DATA_W'($urandom));
        read_frame(1'b1, addr);
        report_test("abort after command byte");

        $display("Summary: %0d tests, %0d failed, %0d compares, %0d errors",
                 tests_run, tests_failed, check_count, error_total());
        if (error_total() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/pet_spi_pkg.sv
verilog/spi_byte.sv
verilog/spi_bridge.sv
verilog/apb_ram.sv
verilog/pet_spi_top.sv
testbench/pet_spi_checker.sv
testbench/tb_pet_spi.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI host-access testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_pet_spi -f files.f -o sim_pet_spi

./obj_dir/sim_pet_spi +verilator+error+limit+100 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
